// File: verilog/vote_params.svh
`ifndef VOTE_PARAMS_SVH
`define VOTE_PARAMS_SVH

// System clock and UART line rate
`define CLK_FREQ_HZ 100000000
`define BAUD_RATE 115200
`define CLKS_PER_BIT (`CLK_FREQ_HZ / `BAUD_RATE)  // 868

// Build-time key, n = 251 * 241
`define KEY_N 16'd60491
`define KEY_N_SQUARED 32'd3659161081

// Blinding LFSR, Galois right shift
`define LFSR_SEED 32'h0000_0001
`define LFSR_TAPS 32'h8020_0003

`define SPI_HALF_PERIOD 4  // System cycles per dclk half period

// ASCII vote characters
`define VOTE_CHAR_0 8'h30
`define VOTE_CHAR_1 8'h31

`endif

// File: verilog/crypto_pkg.sv
`default_nettype none

package crypto_pkg;

  // Residue mod n^2, also the ciphertext width
  typedef logic [31:0] word_t;

  // Exponent and blinding value, both below n
  typedef logic [15:0] key_t;

  // Multiplier accumulator with two guard bits over word_t
  // Doubling plus one addend stays below 4 * n^2
  typedef logic [33:0] acc_t;

endpackage

`default_nettype wire

// File: verilog/io_pkg.sv
`default_nettype none

package io_pkg;

  typedef logic [7:0] byte_t;  // UART payload

  // Vote processor control
  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    WAIT_DONE
  } proc_state_t;

endpackage

`default_nettype wire

// File: verilog/uart_receive.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

module uart_receive (
  input  wire           clk_100mhz,
  input  wire           sys_rst,
  input  wire           rxd,
  output logic          byte_valid,
  output io_pkg::byte_t rx_byte
);
  import io_pkg::*;

  localparam int BAUD_W = $clog2(`CLKS_PER_BIT);
  localparam logic [BAUD_W-1:0] BIT_LAST = BAUD_W'(`CLKS_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] HALF_LAST = BAUD_W'(`CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  logic [1:0] rxd_sync;
  rx_state_t rx_state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0] bit_idx;
  byte_t shift_byte;

  assign rx_byte = shift_byte;  // Held until the next frame's data bits

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      rxd_sync <= 2'b11;  // Line idles high
      rx_state <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx <= '0;
      byte_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      byte_valid <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (rx_state)
        RX_IDLE: begin
          baud_cnt <= '0;
          if (!rxd_sync[1]) rx_state <= RX_START;
        end
        RX_START: if (baud_cnt == HALF_LAST) begin  // Middle of start bit
          baud_cnt <= '0;
          bit_idx <= '0;
          rx_state <= rxd_sync[1] ? RX_IDLE : RX_DATA;  // Glitch, not a start
        end
        RX_DATA: if (baud_cnt == BIT_LAST) begin
          baud_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) rx_state <= RX_STOP;
        end
        default: if (baud_cnt == BIT_LAST) begin
          rx_state <= RX_IDLE;
          byte_valid <= rxd_sync[1];  // Framing error drops the byte
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_100mhz) begin
    if (rx_state == RX_DATA && baud_cnt == BIT_LAST) begin
      shift_byte <= {rxd_sync[1], shift_byte[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: verilog/vote_processor.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

module vote_processor (
  input  wire                clk_100mhz,
  input  wire                sys_rst,
  input  wire                start_btn,
  input  wire                restart_btn,
  input  wire                byte_valid,
  input  wire io_pkg::byte_t rx_byte,
  input  wire                vote_consumed,
  output logic               vote_valid,
  output logic               vote
);
  import io_pkg::*;

  proc_state_t state;
  logic in_flight;  // Survives a restart so only one vote is ever in the chain
  logic is_vote;

  assign is_vote = byte_valid && (rx_byte == `VOTE_CHAR_0 || rx_byte == `VOTE_CHAR_1);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= IDLE;
      in_flight <= 1'b0;
      vote_valid <= 1'b0;
      vote <= 1'b0;
    end else begin
      vote_valid <= 1'b0;
      if (vote_consumed) in_flight <= 1'b0;
      if (restart_btn) begin
        state <= IDLE;
      end else begin
        case (state)
          IDLE: if (start_btn) state <= ARMED;
          ARMED: if (is_vote && !in_flight) begin
            state <= WAIT_DONE;
            vote_valid <= 1'b1;
            vote <= rx_byte[0];  // "0" and "1" differ only in bit 0
            in_flight <= 1'b1;
          end
          WAIT_DONE: if (vote_consumed) state <= ARMED;
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mod_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module mod_multiplier #(
  parameter int WIDTH = $bits(crypto_pkg::acc_t) - 2
) (
  input  wire              clk_100mhz,
  input  wire              sys_rst,
  input  wire              start,
  input  wire [WIDTH-1:0]  a,
  input  wire [WIDTH-1:0]  b,
  input  wire [WIDTH-1:0]  modulus,
  output logic             done,
  output logic [WIDTH-1:0] product
);
  localparam int CNT_W = $clog2(WIDTH + 1);

  logic running;
  logic [CNT_W-1:0] bit_cnt;
  logic [WIDTH-1:0] a_shift;
  logic [WIDTH-1:0] b_reg;
  logic [WIDTH+1:0] mod_ext;
  logic [WIDTH+1:0] acc;  // Always below the modulus between steps
  logic [WIDTH+1:0] summed;
  logic [WIDTH+1:0] first_sub;
  logic [WIDTH+1:0] next_acc;

  // 2*acc + bit*b is below 3*modulus, so two subtractions reduce it
  always_comb begin
    summed = {acc[WIDTH:0], 1'b0} + (a_shift[WIDTH-1] ? {2'b00, b_reg} : '0);
    first_sub = (summed >= mod_ext) ? summed - mod_ext : summed;
    next_acc = (first_sub >= mod_ext) ? first_sub - mod_ext : first_sub;
  end

  assign product = acc[WIDTH-1:0];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      running <= 1'b0;
      bit_cnt <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        bit_cnt <= CNT_W'(WIDTH);
      end else if (running) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == CNT_W'(1)) begin  // Last bit of a
          running <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (start) begin
      a_shift <= a;
      b_reg <= b;
      mod_ext <= {2'b00, modulus};
      acc <= '0;
    end else if (running) begin
      a_shift <= {a_shift[WIDTH-2:0], 1'b0};  // MSB first
      acc <= next_acc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/blinding_exponentiator.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

module blinding_exponentiator (
  input  wire               clk_100mhz,
  input  wire               sys_rst,
  input  wire               draw,
  output logic              blind_valid,
  output crypto_pkg::word_t blind_value
);
  import crypto_pkg::*;

  localparam int KEY_W = $bits(key_t);
  localparam int IDX_W = $clog2(KEY_W);
  localparam word_t MODULUS = `KEY_N_SQUARED;
  localparam key_t EXPONENT = `KEY_N;
  localparam word_t LFSR_MASK = `LFSR_TAPS;

  typedef enum logic [1:0] {X_IDLE, X_DRAW, X_SQUARE, X_MULTIPLY} exp_state_t;

  exp_state_t state;
  word_t lfsr;
  word_t lfsr_next;
  logic r_ok;
  key_t r_value;
  word_t result;
  logic [IDX_W-1:0] bit_idx;
  logic round_end;
  logic mul_start;
  logic mul_done;
  word_t mul_b;
  word_t mul_product;

  assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
  assign r_ok = (lfsr_next[KEY_W-1:0] != '0) && (lfsr_next[KEY_W-1:0] < EXPONENT);

  // A round ends after the square for a clear bit, else after the multiply by r
  assign round_end = mul_done &&
                     (state == X_MULTIPLY || (state == X_SQUARE && !EXPONENT[bit_idx]));
  assign mul_b = (state == X_MULTIPLY) ? word_t'(r_value) : result;
  assign blind_value = result;

  mod_multiplier #(
    .WIDTH($bits(word_t))
  ) i_mod_multiplier (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start(mul_start),
    .a(result),
    .b(mul_b),
    .modulus(MODULUS),
    .done(mul_done),
    .product(mul_product)
  );

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= X_IDLE;
      lfsr <= `LFSR_SEED;
      bit_idx <= '0;
      mul_start <= 1'b0;
      blind_valid <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      blind_valid <= 1'b0;
      case (state)
        X_IDLE: if (draw) state <= X_DRAW;
        X_DRAW: begin
          lfsr <= lfsr_next;  // LFSR only moves while drawing
          if (r_ok) begin
            state <= X_SQUARE;
            bit_idx <= IDX_W'(KEY_W - 1);
            mul_start <= 1'b1;
          end
        end
        X_SQUARE: if (mul_done && EXPONENT[bit_idx]) begin
          state <= X_MULTIPLY;
          mul_start <= 1'b1;
        end
        default: ;
      endcase
      if (round_end) begin
        if (bit_idx == '0) begin
          state <= X_IDLE;
          blind_valid <= 1'b1;
        end else begin
          bit_idx <= bit_idx - 1'b1;
          state <= X_SQUARE;
          mul_start <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (state == X_DRAW && r_ok) begin
      r_value <= lfsr_next[KEY_W-1:0];
      result <= word_t'(1);
    end else if (mul_done) begin
      result <= mul_product;
    end
  end

endmodule

`default_nettype wire

// File: verilog/candidate_encryptor.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

module candidate_encryptor (
  input  wire                    clk_100mhz,
  input  wire                    sys_rst,
  input  wire                    vote_valid,
  input  wire                    vote,
  input  wire                    blind_valid,
  input  wire crypto_pkg::word_t blind_value,
  input  wire                    cipher_taken,
  output logic                   vote_consumed,
  output logic                   cipher_valid,
  output crypto_pkg::word_t      cipher
);
  import crypto_pkg::*;

  localparam word_t MODULUS = `KEY_N_SQUARED;
  localparam word_t G_TO_M1 = word_t'(`KEY_N) + 1;  // g^1 mod n^2 = 1 + n

  logic vote_q;
  logic held;  // Product waiting for SPI to free the output slot
  logic present;
  logic mul_done;
  word_t message_term;
  word_t mul_product;

  assign message_term = vote_q ? G_TO_M1 : word_t'(1);
  assign present = (mul_done || held) && (!cipher_valid || cipher_taken);

  mod_multiplier #(
    .WIDTH($bits(word_t))
  ) i_mod_multiplier (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start(blind_valid),
    .a(message_term),
    .b(blind_value),
    .modulus(MODULUS),
    .done(mul_done),
    .product(mul_product)
  );

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      held <= 1'b0;
      vote_consumed <= 1'b0;
      cipher_valid <= 1'b0;
    end else begin
      vote_consumed <= 1'b0;
      if (cipher_taken) cipher_valid <= 1'b0;
      if (present) begin
        held <= 1'b0;
        vote_consumed <= 1'b1;
        cipher_valid <= 1'b1;
      end else if (mul_done) begin
        held <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (vote_valid) vote_q <= vote;
    if (present) cipher <= mul_product;  // Multiplier output holds until the next start
  end

endmodule

`default_nettype wire

// File: verilog/spi_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

module spi_controller (
  input  wire                    clk_100mhz,
  input  wire                    sys_rst,
  input  wire                    cipher_valid,
  input  wire crypto_pkg::word_t cipher,
  output logic                   cipher_taken,
  output logic                   copi,
  output logic                   dclk,
  output logic                   cs
);
  import crypto_pkg::*;

  localparam int WORD_W = $bits(word_t);
  localparam int HALF_W = $clog2(`SPI_HALF_PERIOD + 1);
  localparam int BIT_W = $clog2(WORD_W);

  logic busy;
  logic half_end;
  logic [HALF_W-1:0] half_cnt;
  logic [BIT_W-1:0] bit_cnt;
  word_t shift_reg;

  assign half_end = (half_cnt == HALF_W'(`SPI_HALF_PERIOD - 1));
  assign cipher_taken = cipher_valid && !busy;
  assign copi = busy && shift_reg[WORD_W-1];  // Mode 0, MSB first

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= 1'b0;
      cs <= 1'b1;
      dclk <= 1'b0;
      half_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (cipher_valid) begin
        busy <= 1'b1;
        cs <= 1'b0;
        half_cnt <= '0;
        bit_cnt <= '0;
      end
    end else begin
      half_cnt <= half_end ? '0 : half_cnt + 1'b1;
      if (half_end) begin
        dclk <= !dclk;
        if (dclk) begin  // Falling edge ends a bit
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == BIT_W'(WORD_W - 1)) begin
            busy <= 1'b0;
            cs <= 1'b1;
          end
        end
      end
    end
  end

  // Next bit appears as dclk falls
  always_ff @(posedge clk_100mhz) begin
    if (cipher_taken) begin
      shift_reg <= cipher;
    end else if (busy && half_end && dclk) begin
      shift_reg <= {shift_reg[WORD_W-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: verilog/vote_encryptor_top.sv
`timescale 1ns/1ps
`default_nettype none

module vote_encryptor_top (
  input  wire  clk_100mhz,
  input  wire  sys_rst,
  input  wire  start_btn,
  input  wire  restart_btn,
  input  wire  uart_rxd,
  output logic copi,
  output logic dclk,
  output logic cs
);
  import crypto_pkg::*;

  // Input side
  logic byte_valid;
  logic [7:0] rx_byte;
  logic vote_valid;
  logic vote;
  logic vote_consumed;

  // Processing to output
  logic blind_valid;
  word_t blind_value;
  logic cipher_valid;
  logic cipher_taken;
  word_t cipher;

  uart_receive i_uart_receive (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .rxd(uart_rxd),
    .byte_valid(byte_valid),
    .rx_byte(rx_byte)
  );

  vote_processor i_vote_processor (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start_btn(start_btn),
    .restart_btn(restart_btn),
    .byte_valid(byte_valid),
    .rx_byte(rx_byte),
    .vote_consumed(vote_consumed),
    .vote_valid(vote_valid),
    .vote(vote)
  );

  blinding_exponentiator i_blinding_exponentiator (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .draw(vote_valid),  // One blinding draw per accepted vote
    .blind_valid(blind_valid),
    .blind_value(blind_value)
  );

  candidate_encryptor i_candidate_encryptor (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .vote_valid(vote_valid),
    .vote(vote),
    .blind_valid(blind_valid),
    .blind_value(blind_value),
    .cipher_taken(cipher_taken),
    .vote_consumed(vote_consumed),
    .cipher_valid(cipher_valid),
    .cipher(cipher)
  );

  spi_controller i_spi_controller (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .cipher_valid(cipher_valid),
    .cipher(cipher),
    .cipher_taken(cipher_taken),
    .copi(copi),
    .dclk(dclk),
    .cs(cs)
  );

endmodule

`default_nettype wire

// File: test/vote_encryptor_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

// Hand-off between candidate_encryptor and spi_controller
module vote_encryptor_properties (
  input wire                    clk_100mhz,
  input wire                    sys_rst,
  input wire                    vote_consumed,
  input wire                    cipher_valid,
  input wire                    cipher_taken,
  input wire crypto_pkg::word_t cipher,
  input wire                    copi,
  input wire                    dclk,
  input wire                    cs
);

  // Mode 0 clock idles low outside a transaction
  dclk_idle_low: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    cs |-> !dclk)
    else $error("dclk high while cs is high");

  cipher_reduced: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    cipher_valid |-> (cipher < `KEY_N_SQUARED))  // Ciphertext is a residue mod n^2
    else $error("cipher not reduced below n squared");

  consumed_one_cycle: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    vote_consumed |=> !vote_consumed)
    else $error("vote_consumed held longer than one cycle");

  // Captured word starts MSB first as cs falls
  cipher_captured: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    cipher_taken |=> (!cs && copi == $past(cipher[31])))
    else $error("SPI frame did not start with the captured cipher MSB");

endmodule

bind vote_encryptor_top vote_encryptor_properties i_vote_encryptor_properties (
  .clk_100mhz(clk_100mhz),
  .sys_rst(sys_rst),
  .vote_consumed(vote_consumed),
  .cipher_valid(cipher_valid),
  .cipher_taken(cipher_taken),
  .cipher(cipher),
  .copi(copi),
  .dclk(dclk),
  .cs(cs)
);

`default_nettype wire

// File: test/vote_encryptor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vote_params.svh"

module vote_encryptor_tb;
  localparam int CS_TIMEOUT = 20000;  // UART frame, gap and encryption
  localparam int BIT_TIMEOUT = 1000;
  localparam int QUIET_CYCLES = 14000;

  logic clk_100mhz = 1'b0;
  logic sys_rst;
  logic start_btn;
  logic restart_btn;
  logic uart_rxd;
  wire copi;
  wire dclk;
  wire cs;

  int error_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  logic [31:0] model_lfsr;  // Reference copy of the blinding LFSR

  vote_encryptor_top i_vote_encryptor_top (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .start_btn(start_btn),
    .restart_btn(restart_btn),
    .uart_rxd(uart_rxd),
    .copi(copi),
    .dclk(dclk),
    .cs(cs)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ `LFSR_TAPS) : (state >> 1);
  endfunction

  // Next r, nonzero and below n
  function automatic logic [15:0] next_draw();
    logic [31:0] state;
    state = lfsr_step(model_lfsr);
    while (state[15:0] == 16'd0 || state[15:0] >= `KEY_N) state = lfsr_step(state);
    model_lfsr = state;
    return state[15:0];
  endfunction

  function automatic longint unsigned pow_mod(input longint unsigned base,
                                              input logic [15:0] exponent);
    longint unsigned result;
    result = 64'd1;
    for (int i = 15; i >= 0; i--) begin
      result = (result * result) % `KEY_N_SQUARED;
      if (exponent[i]) result = (result * base) % `KEY_N_SQUARED;
    end
    return result;
  endfunction

  // c = (1 + m*n) * r^n mod n^2
  function automatic logic [31:0] encrypt_vote(input logic vote, input logic [15:0] r);
    longint unsigned message_term;
    message_term = vote ? (64'd1 + 64'(`KEY_N)) : 64'd1;
    return 32'((message_term * pow_mod(64'(r), `KEY_N)) % `KEY_N_SQUARED);
  endfunction

  // Outputs are settled on the falling clock edge
  task automatic wait_cs(input logic level, input int limit, output logic seen);
    int cycles;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge clk_100mhz);
      seen = (cs == level);
      cycles++;
    end
  endtask

  task automatic capture_frame(output logic [31:0] frame, output logic ok);
    int bits;
    int cycles;
    logic dclk_prev;
    logic seen;
    frame = '0;
    bits = 0;
    cycles = 0;
    ok = 1'b0;
    wait_cs(1'b0, CS_TIMEOUT, seen);
    if (!seen) begin
      $display("timeout at %0t: no SPI transaction started", $time);
      error_count++;
      return;
    end
    dclk_prev = dclk;
    while (bits < 32 && cycles < BIT_TIMEOUT) begin
      @(negedge clk_100mhz);
      if (dclk && !dclk_prev) begin
        frame = {frame[30:0], copi};  // MSB first
        bits++;
      end
      dclk_prev = dclk;
      cycles++;
    end
    wait_cs(1'b1, BIT_TIMEOUT, seen);
    if (bits != 32 || !seen) begin
      $display("broken SPI frame at %0t: %0d bits, cs released %0b", $time, bits, seen);
      error_count++;
    end else begin
      ok = 1'b1;
    end
  endtask

  task automatic check_quiet(input int cycles);
    logic bad;
    bad = 1'b0;
    repeat (cycles) begin
      @(negedge clk_100mhz);
      if (cs !== 1'b1 || dclk !== 1'b0 || copi !== 1'b0) bad = 1'b1;
    end
    if (bad) begin
      $display("unexpected SPI activity before %0t", $time);
      error_count++;
    end
  endtask

  // 8N1 frame after a random idle gap
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    int gap;
    frame = {1'b1, data, 1'b0};
    gap = 20 + int'($urandom % 200);
    repeat (gap) @(posedge clk_100mhz);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_100mhz);
      #1;
      uart_rxd = frame[i];
      repeat (`CLKS_PER_BIT - 1) @(posedge clk_100mhz);
    end
  endtask

  task automatic press_start();
    @(posedge clk_100mhz);
    #1;
    start_btn = 1'b1;
    repeat (3) @(posedge clk_100mhz);
    #1;
    start_btn = 1'b0;
  endtask

  task automatic press_restart();
    @(posedge clk_100mhz);
    #1;
    restart_btn = 1'b1;
    repeat (3) @(posedge clk_100mhz);
    #1;
    restart_btn = 1'b0;
  endtask

  task automatic send_and_check(input logic [7:0] data, input logic [31:0] expected);
    logic [31:0] frame;
    logic ok;
    fork
      send_byte(data);
      capture_frame(frame, ok);
    join
    if (ok && frame !== expected) begin
      $display("mismatch at %0t: frame %h, expected %h", $time, frame, expected);
      error_count++;
    end
  endtask

  task automatic send_ignored(input logic [7:0] data);
    fork
      send_byte(data);
      check_quiet(QUIET_CYCLES);
    join
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic test_reset_idle();
    int errors_before;
    errors_before = error_count;
    check_quiet(20);
    send_ignored(`VOTE_CHAR_1);  // Not armed yet
    finish_test("reset and idle", errors_before);
  endtask

  task automatic test_single_vote();
    int errors_before;
    logic [15:0] r;
    errors_before = error_count;
    press_start();
    r = next_draw();
    send_and_check(`VOTE_CHAR_1, encrypt_vote(1'b1, r));
    finish_test("single vote", errors_before);
  endtask

  task automatic test_two_votes();
    int errors_before;
    logic [15:0] r;
    errors_before = error_count;
    r = next_draw();
    send_and_check(`VOTE_CHAR_0, 32'(pow_mod(64'(r), `KEY_N)));  // g^0 leaves r^n alone
    r = next_draw();
    send_and_check(`VOTE_CHAR_1, encrypt_vote(1'b1, r));
    finish_test("two votes", errors_before);
  endtask

  task automatic test_invalid_bytes();
    int errors_before;
    logic [15:0] r;
    errors_before = error_count;
    send_ignored(8'h41);
    send_ignored(8'h32);
    r = next_draw();
    send_and_check(`VOTE_CHAR_1, encrypt_vote(1'b1, r));
    finish_test("invalid bytes", errors_before);
  endtask

  task automatic test_restart();
    int errors_before;
    logic [15:0] r;
    errors_before = error_count;
    press_restart();
    send_ignored(`VOTE_CHAR_0);
    press_start();
    r = next_draw();
    send_and_check(`VOTE_CHAR_1, encrypt_vote(1'b1, r));
    finish_test("restart", errors_before);
  endtask

  initial begin
    void'($urandom(32'hcbb7));
    sys_rst = 1'b1;
    start_btn = 1'b0;
    restart_btn = 1'b0;
    uart_rxd = 1'b1;  // UART line idles high
    model_lfsr = `LFSR_SEED;
    repeat (5) @(posedge clk_100mhz);
    #1;
    sys_rst = 1'b0;
    test_reset_idle();
    test_single_vote();
    test_two_votes();
    test_invalid_bytes();
    test_restart();
    $display("tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/crypto_pkg.sv
verilog/io_pkg.sv
verilog/uart_receive.sv
verilog/vote_processor.sv
verilog/mod_multiplier.sv
verilog/blinding_exponentiator.sv
verilog/candidate_encryptor.sv
verilog/spi_controller.sv
verilog/vote_encryptor_top.sv
test/vote_encryptor_properties.sv
test/vote_encryptor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the vote encryptor testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vote_encryptor_tb -f sources.f -o vote_sim \
  && { ./obj_dir/vote_sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -qx "TESTS PASSED" sim.log \
  || { echo "simulation failed"; exit 1; }
echo "simulation passed"
